//--- include/rename_consts.svh
`ifndef RENAME_CONSTS_SVH
`define RENAME_CONSTS_SVH

// register file sizes
`define ARCH_REGS 32
`define PHY_REGS 64

// register number widths
`define ARCH_W $clog2(`ARCH_REGS)
`define PHY_W $clog2(`PHY_REGS)

// reorder buffer depth and slot id width
`define ROB_DEPTH 16
`define ROB_W $clog2(`ROB_DEPTH)

`endif

//--- source/reg_map_pkg.sv
`include "rename_consts.svh"

package reg_map_pkg;

    // architectural register number, x0 to x31
    typedef logic [`ARCH_W-1:0] arch_reg_t;

    // physical register number
    typedef logic [`PHY_W-1:0] phy_reg_t;

    // full map table, entry i at bits [i*PHY_W +: PHY_W]
    typedef logic [`ARCH_REGS*`PHY_W-1:0] map_vec_t;

endpackage

//--- source/rob_pkg.sv
`include "rename_consts.svh"

package rob_pkg;

    // reorder buffer slot
    typedef logic [`ROB_W-1:0] rob_id_t;

    // occupancy, one bit wider so a full buffer fits
    typedef logic [`ROB_W:0] rob_count_t;

endpackage

//--- source/front_rat.sv
`timescale 1ns/1ps

`include "rename_consts.svh"

module front_rat import reg_map_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flush,
    input  arch_reg_t rs1_arch,
    input  arch_reg_t rs2_arch,
    input  arch_reg_t rd_arch,
    input  logic      alloc_fire,
    input  phy_reg_t  alloc_phy,
    input  map_vec_t  back_map,
    output phy_reg_t  rs1_phy,
    output phy_reg_t  rs2_phy,
    output phy_reg_t  old_phy
);

    // speculative mapping, one entry per architectural register
    phy_reg_t map_q [`ARCH_REGS];

    // source lookups and the mapping that rd is about to replace
    assign rs1_phy = map_q[rs1_arch];
    assign rs2_phy = map_q[rs2_arch];
    assign old_phy = map_q[rd_arch];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // identity map out of reset
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= phy_reg_t'(i);
            end
        end else if (flush) begin
            // drop all speculative renames, restart from committed state
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= back_map[i*`PHY_W +: `PHY_W];
            end
        end else if (alloc_fire && (rd_arch != '0)) begin
            map_q[rd_arch] <= alloc_phy;
        end
    end

endmodule

//--- source/free_list.sv
`timescale 1ns/1ps

`include "rename_consts.svh"

module free_list import reg_map_pkg::*; (
    input  logic     clk,
    input  logic     rst,
    input  logic     flush,
    input  logic     alloc_fire,
    input  logic     release_valid,
    input  phy_reg_t release_phy,
    input  map_vec_t back_map,
    output logic     free_avail,
    output phy_reg_t alloc_phy
);

    // one bit per physical register, set means free
    logic [`PHY_REGS-1:0] free_q;

    // registers held by the committed map
    logic [`PHY_REGS-1:0] held_vec;

    assign free_avail = |free_q;

    // lowest free index wins, scan from the top down
    always_comb begin
        alloc_phy = '0;
        for (int i = `PHY_REGS-1; i >= 0; i--) begin
            if (free_q[i]) begin
                alloc_phy = phy_reg_t'(i);
            end
        end
    end

    always_comb begin
        held_vec = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            held_vec[back_map[i*`PHY_W +: `PHY_W]] = 1'b1;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            // low half backs the identity map
            free_q <= {{(`PHY_REGS-`ARCH_REGS){1'b1}}, {`ARCH_REGS{1'b0}}};
        end else if (flush) begin
            free_q <= ~held_vec;
        end else begin
            if (alloc_fire) begin
                free_q[alloc_phy] <= 1'b0;
            end
            // released register is never the one being allocated
            if (release_valid) begin
                free_q[release_phy] <= 1'b1;
            end
        end
    end

endmodule

//--- source/reorder_buffer.sv
`timescale 1ns/1ps

`include "rename_consts.svh"

module reorder_buffer import reg_map_pkg::*, rob_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rename_valid,
    input  arch_reg_t rd_arch,
    input  logic      free_avail,
    input  phy_reg_t  alloc_phy,
    input  phy_reg_t  old_phy,
    input  logic      complete_valid,
    input  rob_id_t   complete_rob_id,
    input  logic      complete_mispredict,
    output logic      rename_ready,
    output logic      alloc_fire,
    output phy_reg_t  rd_phy,
    output rob_id_t   rob_id,
    output logic      retire_valid,
    output arch_reg_t retire_rd_arch,
    output phy_reg_t  retire_rd_phy,
    output logic      release_valid,
    output phy_reg_t  release_phy,
    output logic      flush
);

    rob_id_t    head_q;
    rob_id_t    tail_q;
    rob_count_t count_q;

    // per-slot payload
    arch_reg_t ent_rd_arch [`ROB_DEPTH];
    phy_reg_t  ent_new_phy [`ROB_DEPTH];
    phy_reg_t  ent_old_phy [`ROB_DEPTH];

    // per-slot status
    logic [`ROB_DEPTH-1:0] ent_done;
    logic [`ROB_DEPTH-1:0] ent_misp;

    // set while the retiring entry was mispredicted
    logic retire_misp;

    logic recovering;
    logic full;
    logic rename_fire;
    logic pop;

    // retire cycle of a bad entry, then the flush cycle
    assign recovering = (retire_valid && retire_misp) || flush;
    assign full = (count_q == rob_count_t'(`ROB_DEPTH));

    assign rename_ready = !full && (free_avail || (rd_arch == '0)) && !recovering;
    assign rename_fire = rename_valid && rename_ready;
    assign alloc_fire = rename_fire && (rd_arch != '0);

    // x0 keeps physical register 0
    assign rd_phy = alloc_fire ? alloc_phy : '0;
    assign rob_id = tail_q;

    assign pop = (count_q != '0) && ent_done[head_q] && !recovering;

    assign release_valid = retire_valid && (retire_rd_arch != '0);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            head_q <= '0;
            tail_q <= '0;
            count_q <= '0;
            ent_done <= '0;
            ent_misp <= '0;
            retire_valid <= 1'b0;
            retire_misp <= 1'b0;
            flush <= 1'b0;
        end else begin
            retire_valid <= pop;
            retire_misp <= pop && ent_misp[head_q];
            flush <= retire_valid && retire_misp;

            if (flush) begin
                // everything younger than the bad entry is gone
                head_q <= tail_q;
                count_q <= '0;
            end else begin
                if (pop) begin
                    head_q <= head_q + 1'b1;
                end
                if (rename_fire) begin
                    tail_q <= tail_q + 1'b1;
                end
                case ({rename_fire, pop})
                    2'b10: count_q <= count_q + 1'b1;
                    2'b01: count_q <= count_q - 1'b1;
                    default: count_q <= count_q;
                endcase
            end

            if (complete_valid && !recovering) begin
                ent_done[complete_rob_id] <= 1'b1;
                ent_misp[complete_rob_id] <= complete_mispredict;
            end
            // new entry starts not done
            if (rename_fire) begin
                ent_done[tail_q] <= 1'b0;
                ent_misp[tail_q] <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (rename_fire) begin
            ent_rd_arch[tail_q] <= rd_arch;
            ent_new_phy[tail_q] <= rd_phy;
            ent_old_phy[tail_q] <= old_phy;
        end
        if (pop) begin
            retire_rd_arch <= ent_rd_arch[head_q];
            retire_rd_phy <= ent_new_phy[head_q];
            release_phy <= ent_old_phy[head_q];
        end
    end

endmodule

//--- source/back_rat.sv
`timescale 1ns/1ps

`include "rename_consts.svh"

module back_rat import reg_map_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      retire_valid,
    input  arch_reg_t retire_rd_arch,
    input  phy_reg_t  retire_rd_phy,
    output map_vec_t  back_map
);

    // committed mapping
    phy_reg_t map_q [`ARCH_REGS];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `ARCH_REGS; i++) begin
                map_q[i] <= phy_reg_t'(i);
            end
        end else if (retire_valid && (retire_rd_arch != '0)) begin
            map_q[retire_rd_arch] <= retire_rd_phy;
        end
    end

    // flatten for the front map and free list
    always_comb begin
        back_map = '0;
        for (int i = 0; i < `ARCH_REGS; i++) begin
            back_map[i*`PHY_W +: `PHY_W] = map_q[i];
        end
    end

endmodule

//--- source/rename_top.sv
`timescale 1ns/1ps

module rename_top import reg_map_pkg::*, rob_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      rename_valid,
    input  arch_reg_t rs1_arch,
    input  arch_reg_t rs2_arch,
    input  arch_reg_t rd_arch,
    input  logic      complete_valid,
    input  rob_id_t   complete_rob_id,
    input  logic      complete_mispredict,
    output logic      rename_ready,
    output phy_reg_t  rs1_phy,
    output phy_reg_t  rs2_phy,
    output phy_reg_t  rd_phy,
    output rob_id_t   rob_id,
    output logic      retire_valid,
    output arch_reg_t retire_rd_arch,
    output phy_reg_t  retire_rd_phy,
    output logic      flush
);

    logic     alloc_fire;
    logic     free_avail;
    phy_reg_t alloc_phy;
    phy_reg_t old_phy;
    logic     release_valid;
    phy_reg_t release_phy;
    map_vec_t back_map;

    front_rat front_rat0 (
        .clk        (clk),
        .rst        (rst),
        .flush      (flush),
        .rs1_arch   (rs1_arch),
        .rs2_arch   (rs2_arch),
        .rd_arch    (rd_arch),
        .alloc_fire (alloc_fire),
        .alloc_phy  (alloc_phy),
        .back_map   (back_map),
        .rs1_phy    (rs1_phy),
        .rs2_phy    (rs2_phy),
        .old_phy    (old_phy)
    );

    free_list free_list0 (
        .clk           (clk),
        .rst           (rst),
        .flush         (flush),
        .alloc_fire    (alloc_fire),
        .release_valid (release_valid),
        .release_phy   (release_phy),
        .back_map      (back_map),
        .free_avail    (free_avail),
        .alloc_phy     (alloc_phy)
    );

    reorder_buffer rob0 (
        .clk                 (clk),
        .rst                 (rst),
        .rename_valid        (rename_valid),
        .rd_arch             (rd_arch),
        .free_avail          (free_avail),
        .alloc_phy           (alloc_phy),
        .old_phy             (old_phy),
        .complete_valid      (complete_valid),
        .complete_rob_id     (complete_rob_id),
        .complete_mispredict (complete_mispredict),
        .rename_ready        (rename_ready),
        .alloc_fire          (alloc_fire),
        .rd_phy              (rd_phy),
        .rob_id              (rob_id),
        .retire_valid        (retire_valid),
        .retire_rd_arch      (retire_rd_arch),
        .retire_rd_phy       (retire_rd_phy),
        .release_valid       (release_valid),
        .release_phy         (release_phy),
        .flush               (flush)
    );

    // committed map, also the restore source on flush
    back_rat back_rat0 (
        .clk            (clk),
        .rst            (rst),
        .retire_valid   (retire_valid),
        .retire_rd_arch (retire_rd_arch),
        .retire_rd_phy  (retire_rd_phy),
        .back_map       (back_map)
    );

endmodule

//--- tb/rename_chk.sv
`timescale 1ns/1ps

module rename_chk (
    input logic clk,
    input logic rst,
    input logic flush,
    input logic retire_valid,
    input logic rename_ready
);

    // number of failed assertions
    int fail_count = 0;

    // recovery pulse is a single cycle
    flush_one_cycle: assert property (
        @(posedge clk) disable iff (rst) flush |=> !flush
    ) else begin
        $error("flush stayed high for more than one cycle");
        fail_count++;
    end

    // only a retiring bad entry starts recovery
    flush_after_retire: assert property (
        @(posedge clk) disable iff (rst) flush |-> $past(retire_valid)
    ) else begin
        $error("flush without a retire in the cycle before");
        fail_count++;
    end

    // no renames while the maps are restored
    no_rename_in_flush: assert property (
        @(posedge clk) disable iff (rst) flush |-> !rename_ready
    ) else begin
        $error("rename_ready high during flush");
        fail_count++;
    end

    // buffer is empty right out of reset
    quiet_after_reset: assert property (
        @(posedge clk) $fell(rst) |-> !retire_valid
    ) else begin
        $error("retire_valid high directly after reset");
        fail_count++;
    end

endmodule

//--- tb/rename_tb.sv
`timescale 1ns/1ps

`include "rename_consts.svh"

module rename_tb import reg_map_pkg::*, rob_pkg::*; ();

    localparam int NUM_REQ = 2000;
    localparam int CYCLE_LIMIT = 4 * NUM_REQ;
    localparam logic [31:0] SEED = 32'hcb2d_335a;

    logic      clk = 1'b0;
    logic      rst;
    logic      rename_valid;
    arch_reg_t rs1_arch;
    arch_reg_t rs2_arch;
    arch_reg_t rd_arch;
    logic      complete_valid;
    rob_id_t   complete_rob_id;
    logic      complete_mispredict;
    logic      rename_ready;
    phy_reg_t  rs1_phy;
    phy_reg_t  rs2_phy;
    phy_reg_t  rd_phy;
    rob_id_t   rob_id;
    logic      retire_valid;
    arch_reg_t retire_rd_arch;
    phy_reg_t  retire_rd_phy;
    logic      flush;

    logic [31:0] rng_state;
    int cycle_count = 0;
    int requests;
    int flush_count;
    int full_count;
    int retire_count;

    // reference model state
    phy_reg_t             m_front [`ARCH_REGS];
    phy_reg_t             m_back [`ARCH_REGS];
    logic [`PHY_REGS-1:0] m_free;
    arch_reg_t            e_rd [`ROB_DEPTH];
    phy_reg_t             e_new [`ROB_DEPTH];
    phy_reg_t             e_old [`ROB_DEPTH];
    logic                 e_done [`ROB_DEPTH];
    logic                 e_misp [`ROB_DEPTH];
    int                   m_head;
    int                   m_tail;
    int                   m_count;
    logic                 m_ret_valid;
    logic                 m_ret_misp;
    arch_reg_t            m_ret_rd;
    phy_reg_t             m_ret_new;
    phy_reg_t             m_ret_old;
    logic                 m_flush;
    logic                 exp_ready;
    logic                 recov;

    rename_top dut0 (
        .clk                 (clk),
        .rst                 (rst),
        .rename_valid        (rename_valid),
        .rs1_arch            (rs1_arch),
        .rs2_arch            (rs2_arch),
        .rd_arch             (rd_arch),
        .complete_valid      (complete_valid),
        .complete_rob_id     (complete_rob_id),
        .complete_mispredict (complete_mispredict),
        .rename_ready        (rename_ready),
        .rs1_phy             (rs1_phy),
        .rs2_phy             (rs2_phy),
        .rd_phy              (rd_phy),
        .rob_id              (rob_id),
        .retire_valid        (retire_valid),
        .retire_rd_arch      (retire_rd_arch),
        .retire_rd_phy       (retire_rd_phy),
        .flush               (flush)
    );

    bind rename_top rename_chk chk0 (
        .clk          (clk),
        .rst          (rst),
        .flush        (flush),
        .retire_valid (retire_valid),
        .rename_ready (rename_ready)
    );

    always #10 clk = ~clk;

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("CHECKS FAILED");
            $fatal(1, "timeout");
        end
    end

    // a failed bound assertion ends the run
    initial begin
        wait (dut0.chk0.fail_count != 0);
        $display("a bound assertion in rename_chk failed");
        $display("CHECKS FAILED");
        $fatal(1, "assertion failure");
    end

    function automatic logic [31:0] next_rand();
        rng_state = rng_state * 32'd1664525 + 32'd1013904223;
        return rng_state;
    endfunction

    task automatic check_equal(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("Error: %s expected %0h actual %0h", name, expected, actual);
            $display("CHECKS FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    // lowest set bit of the model free vector or -1
    function automatic int lowest_free();
        int idx;
        idx = -1;
        for (int i = 0; i < `PHY_REGS; i++) begin
            if (idx < 0 && m_free[i]) begin
                idx = i;
            end
        end
        return idx;
    endfunction

    function automatic logic model_idle();
        return (m_count == 0) && !m_ret_valid && !m_flush;
    endfunction

    task automatic reset_model();
        for (int i = 0; i < `ARCH_REGS; i++) begin
            m_front[i] = phy_reg_t'(i);
            m_back[i] = phy_reg_t'(i);
        end
        for (int i = 0; i < `PHY_REGS; i++) begin
            m_free[i] = (i >= `ARCH_REGS);
        end
        for (int i = 0; i < `ROB_DEPTH; i++) begin
            e_done[i] = 1'b0;
            e_misp[i] = 1'b0;
        end
        m_head = 0;
        m_tail = 0;
        m_count = 0;
        m_ret_valid = 1'b0;
        m_ret_misp = 1'b0;
        m_flush = 1'b0;
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        int cand [`ROB_DEPTH];
        int ncand;
        int slot;
        r = next_rand();
        if (requests < NUM_REQ && r[31:29] != 3'b000) begin
            rename_valid = 1'b1;
            requests++;
        end else begin
            rename_valid = 1'b0;
        end
        rs1_arch = r[28:24];
        rs2_arch = r[23:19];
        rd_arch = r[18:14];

        r = next_rand();
        complete_valid = 1'b0;
        complete_rob_id = '0;
        complete_mispredict = 1'b0;
        ncand = 0;
        for (int k = 0; k < m_count; k++) begin
            slot = (m_head + k) % `ROB_DEPTH;
            if (!e_done[slot]) begin
                cand[ncand] = slot;
                ncand++;
            end
        end
        // completions held back for a stretch so the buffer fills
        if ((cycle_count % 128) < 96 && r[31:30] != 2'b00 && ncand > 0) begin
            complete_valid = 1'b1;
            complete_rob_id = rob_id_t'(cand[int'(r[27:16]) % ncand]);
            complete_mispredict = (r[3:0] == 4'h0);
        end
    endtask

    task automatic check_outputs();
        int lf;
        lf = lowest_free();
        recov = (m_ret_valid && m_ret_misp) || m_flush;
        exp_ready = (m_count < `ROB_DEPTH) && (lf >= 0 || rd_arch == '0) && !recov;
        check_equal("rename_ready", exp_ready, rename_ready);
        check_equal("retire_valid", m_ret_valid, retire_valid);
        check_equal("flush", m_flush, flush);
        if (m_ret_valid) begin
            check_equal("retire_rd_arch", m_ret_rd, retire_rd_arch);
            check_equal("retire_rd_phy", m_ret_new, retire_rd_phy);
        end
        check_equal("rs1_phy", m_front[rs1_arch], rs1_phy);
        check_equal("rs2_phy", m_front[rs2_arch], rs2_phy);
        check_equal("rob_id", m_tail, rob_id);
        if (rename_valid && exp_ready && rd_arch != '0) begin
            check_equal("rd_phy", lf, rd_phy);
        end else begin
            check_equal("rd_phy", 0, rd_phy);
        end
    endtask

    // state change at the rising edge that ends this cycle
    task automatic advance_model();
        logic     fire;
        logic     pop;
        logic     nxt_flush;
        phy_reg_t new_phy;
        phy_reg_t old_phy;
        fire = rename_valid && exp_ready;
        pop = (m_count > 0) && e_done[m_head] && !recov;
        nxt_flush = m_ret_valid && m_ret_misp;
        if (m_count == `ROB_DEPTH) begin
            full_count++;
        end
        if (m_flush) begin
            flush_count++;
        end

        if (fire) begin
            old_phy = m_front[rd_arch];
            new_phy = '0;
            if (rd_arch != '0) begin
                new_phy = phy_reg_t'(lowest_free());
                m_free[new_phy] = 1'b0;
                m_front[rd_arch] = new_phy;
            end
            e_rd[m_tail] = rd_arch;
            e_new[m_tail] = new_phy;
            e_old[m_tail] = old_phy;
            e_done[m_tail] = 1'b0;
            e_misp[m_tail] = 1'b0;
        end

        if (complete_valid && !recov) begin
            e_done[complete_rob_id] = 1'b1;
            e_misp[complete_rob_id] = complete_mispredict;
        end

        // commit the entry reported this cycle
        if (m_ret_valid) begin
            retire_count++;
            if (m_ret_rd != '0) begin
                m_back[m_ret_rd] = m_ret_new;
                m_free[m_ret_old] = 1'b1;
            end
        end

        if (pop) begin
            m_ret_rd = e_rd[m_head];
            m_ret_new = e_new[m_head];
            m_ret_old = e_old[m_head];
            m_ret_misp = e_misp[m_head];
        end else begin
            m_ret_misp = 1'b0;
        end

        if (m_flush) begin
            m_free = '1;
            for (int i = 0; i < `ARCH_REGS; i++) begin
                m_front[i] = m_back[i];
                m_free[m_back[i]] = 1'b0;
            end
            m_head = m_tail;
            m_count = 0;
        end else begin
            if (pop) begin
                m_head = (m_head + 1) % `ROB_DEPTH;
                m_count--;
            end
            if (fire) begin
                m_tail = (m_tail + 1) % `ROB_DEPTH;
                m_count++;
            end
        end

        m_ret_valid = pop;
        m_flush = nxt_flush;
    endtask

    initial begin
        rst = 1'b1;
        rename_valid = 1'b0;
        rs1_arch = '0;
        rs2_arch = '0;
        rd_arch = '0;
        complete_valid = 1'b0;
        complete_rob_id = '0;
        complete_mispredict = 1'b0;
        rng_state = SEED;
        requests = 0;
        flush_count = 0;
        full_count = 0;
        retire_count = 0;
        reset_model();

        repeat (2) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        while (requests < NUM_REQ || !model_idle()) begin
            drive_inputs();
            #5;
            check_outputs();
            advance_model();
            @(negedge clk);
        end

        if (flush_count == 0 || full_count == 0 || retire_count == 0) begin
            $display("run never reached a flush, a full buffer or a retire");
            $display("CHECKS FAILED");
            $fatal(1, "stimulus did not reach all cases");
        end else begin
            $display("ALL CHECKS PASSED");
            $finish;
        end
    end

endmodule

//--- verilog.f
+incdir+include
source/reg_map_pkg.sv
source/rob_pkg.sv
source/front_rat.sv
source/free_list.sv
source/reorder_buffer.sv
source/back_rat.sv
source/rename_top.sv
tb/rename_chk.sv
tb/rename_tb.sv
